// File: rvExecPkg.sv
// Shared widths, opcodes, control encodings and stage payloads of the rvExec slice.
// Design modules import it inside their bodies and use scoped names in port lists.
`default_nettype none

package rvExecPkg;

  localparam int xlen     = 32;  // data and address width
  localparam int regAddrW = 5;   // x0..x31

  // major opcodes, instWord[6:0]
  localparam logic [6:0] opCompute  = 7'b0110011;
  localparam logic [6:0] opICompute = 7'b0010011;
  localparam logic [6:0] opBranch   = 7'b1100011;
  localparam logic [6:0] opLoad     = 7'b0000011;
  localparam logic [6:0] opStore    = 7'b0100011;
  localparam logic [6:0] opJal      = 7'b1101111;
  localparam logic [6:0] opJalr     = 7'b1100111;
  localparam logic [6:0] opLui      = 7'b0110111;
  localparam logic [6:0] opAuipc    = 7'b0010111;

  typedef enum logic [2:0] {
    immNone, immI, immS, immB, immU, immJ, immShamt
  } immSelT;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu,
    aluXor, aluSrl, aluSra, aluOr, aluAnd
  } aluOpT;

  // brAlways covers jal and jalr
  typedef enum logic [2:0] {
    brNever, brEq, brNe, brLt, brGe, brLtu, brGeu, brAlways
  } brCondT;

  typedef enum logic [1:0] {
    wbAlu, wbPc4, wbImm
  } wbSelT;

  // encoding matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    sizeByte, sizeHalf, sizeWord
  } memSizeT;

  typedef enum logic [1:0] {
    haltNone, haltIllegal, haltMemAlign, haltPcAlign
  } haltCauseT;

  typedef struct packed {
    logic [xlen-1:0]     pc;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic [xlen-1:0]     imm;
    logic [regAddrW-1:0] rd;
    aluOpT               aluOp;
    brCondT              brCond;
    wbSelT               wbSel;
    memSizeT             memSize;
    logic                aluSrcPc;   // operand A is pc
    logic                aluSrcImm;  // operand B is imm
    logic                regWrite;
    logic                memRead;
    logic                memWrite;
    logic                illegal;
  } decodedT;

  typedef struct packed {
    logic [xlen-1:0]     result;
    logic [regAddrW-1:0] rd;
    logic                regWrite;
    logic [xlen-1:0]     nextPc;
    logic [xlen-1:0]     memAddr;
    logic [xlen-1:0]     storeData;
    memSizeT             memSize;
    logic                memRead;
    logic                memWrite;
    haltCauseT           haltCause;
  } execResultT;

endpackage

`default_nettype wire

// File: pipeReg.sv
// One-entry valid/ready pipeline register for any packed payload type.
// Used for both rvExec stages; accepts when empty or when draining.
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    inValid,
  output logic    inReady,
  input  payloadT inData,
  output logic    outValid,
  input  logic    outReady,
  output payloadT outData
);

  assign inReady = !outValid || outReady;  // empty or emptying this edge

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      outData <= inData;
    end
  end

  // a stalled output keeps its payload until it is taken
  aHoldData: assert property (@(posedge clk) disable iff (!arstN)
    outValid && !outReady |=> $stable(outData))
    else $error("pipeReg payload changed while stalled");

  aHoldValid: assert property (@(posedge clk) disable iff (!arstN)
    outValid && !outReady |=> outValid)
    else $error("pipeReg dropped valid without a transfer");

endmodule

`default_nettype wire

// File: immGen.sv
// Immediate generation for the RV32I formats decoded by this slice.
// Sign-extends I/S/B/J, places U in the upper bits, zero-extends shamt.
`timescale 1ns/1ps
`default_nettype none

module immGen (
  input  logic [rvExecPkg::xlen-1:0] instWord,
  input  rvExecPkg::immSelT          immSel,
  output logic [rvExecPkg::xlen-1:0] imm
);
  import rvExecPkg::*;

  logic sign;

  assign sign = instWord[31];

  always_comb begin
    case (immSel)
      immI:     imm = {{20{sign}}, instWord[31:20]};
      immS:     imm = {{20{sign}}, instWord[31:25], instWord[11:7]};
      immB:     imm = {{19{sign}}, sign, instWord[7], instWord[30:25],
                       instWord[11:8], 1'b0};               // halfword offset
      immU:     imm = {instWord[31:12], 12'b0};
      immJ:     imm = {{11{sign}}, sign, instWord[19:12], instWord[20],
                       instWord[30:21], 1'b0};
      immShamt: imm = {27'b0, instWord[24:20]};              // slli/srli/srai
      default:  imm = '0;                                    // R-type, no imm
    endcase
  end

endmodule

`default_nettype wire

// File: instDecoder.sv
// Stage-one decode: opcode/funct3/funct7 to ALU, branch, writeback and memory
// controls, plus the immediate. Unsupported encodings are flagged illegal.
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
  input  logic [rvExecPkg::xlen-1:0] instWord,
  input  logic [rvExecPkg::xlen-1:0] pc,
  input  logic [rvExecPkg::xlen-1:0] rs1Data,
  input  logic [rvExecPkg::xlen-1:0] rs2Data,
  output rvExecPkg::decodedT         decoded
);
  import rvExecPkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  immSelT          immSel;
  logic [xlen-1:0] imm;
  aluOpT           baseOp;  // funct3 mapping shared by R and I types

  assign opcode = instWord[6:0];
  assign funct3 = instWord[14:12];
  assign funct7 = instWord[31:25];

  immGen immGenInst (.instWord(instWord), .immSel(immSel), .imm(imm));

  always_comb begin
    case (opcode)
      opICompute:     immSel = (funct3[1:0] == 2'b01) ? immShamt : immI;  // shifts
      opLoad, opJalr: immSel = immI;
      opStore:        immSel = immS;
      opBranch:       immSel = immB;
      opJal:          immSel = immJ;
      opLui, opAuipc: immSel = immU;
      default:        immSel = immNone;
    endcase
  end

  always_comb begin
    case (funct3)
      3'd0:    baseOp = aluAdd;
      3'd1:    baseOp = aluSll;
      3'd2:    baseOp = aluSlt;
      3'd3:    baseOp = aluSltu;
      3'd4:    baseOp = aluXor;
      3'd5:    baseOp = (funct7 == 7'h20) ? aluSra : aluSrl;
      3'd6:    baseOp = aluOr;
      default: baseOp = aluAnd;
    endcase
  end

  always_comb begin
    decoded           = '0;
    decoded.pc        = pc;
    decoded.rs1Data   = rs1Data;
    decoded.rs2Data   = rs2Data;
    decoded.imm       = imm;
    decoded.rd        = instWord[11:7];
    decoded.aluOp     = aluAdd;
    decoded.brCond    = brNever;
    decoded.wbSel     = wbAlu;
    decoded.memSize   = memSizeT'(funct3[1:0]);
    case (opcode)
      opCompute: begin
        decoded.regWrite = 1'b1;
        decoded.aluOp    = (funct3 == 3'd0 && funct7 == 7'h20) ? aluSub : baseOp;
        if (funct7 == 7'h20) begin
          decoded.illegal = (funct3 != 3'd0) && (funct3 != 3'd5);  // only sub/sra
        end else begin
          decoded.illegal = (funct7 != 7'h00);  // M extension lands here
        end
      end
      opICompute: begin
        decoded.regWrite  = 1'b1;
        decoded.aluSrcImm = 1'b1;
        decoded.aluOp     = baseOp;
        if (funct3 == 3'd1) begin
          decoded.illegal = (funct7 != 7'h00);
        end else if (funct3 == 3'd5) begin
          decoded.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end
      opLoad: begin
        decoded.regWrite  = 1'b1;  // load data returns outside the slice
        decoded.memRead   = 1'b1;
        decoded.aluSrcImm = 1'b1;
        decoded.illegal   = (funct3 > 3'd2);  // no lbu/lhu
      end
      opStore: begin
        decoded.memWrite  = 1'b1;
        decoded.aluSrcImm = 1'b1;
        decoded.illegal   = (funct3 > 3'd2);
      end
      opBranch: begin
        decoded.aluSrcPc  = 1'b1;
        decoded.aluSrcImm = 1'b1;
        case (funct3)
          3'd0:    decoded.brCond = brEq;
          3'd1:    decoded.brCond = brNe;
          3'd4:    decoded.brCond = brLt;
          3'd5:    decoded.brCond = brGe;
          3'd6:    decoded.brCond = brLtu;
          3'd7:    decoded.brCond = brGeu;
          default: decoded.illegal = 1'b1;
        endcase
      end
      opJal, opJalr: begin
        decoded.regWrite  = 1'b1;
        decoded.wbSel     = wbPc4;
        decoded.brCond    = brAlways;
        decoded.aluSrcPc  = (opcode == opJal);  // jalr targets rs1 + imm
        decoded.aluSrcImm = 1'b1;
      end
      opLui: begin
        decoded.regWrite = 1'b1;
        decoded.wbSel    = wbImm;
      end
      opAuipc: begin
        decoded.regWrite  = 1'b1;
        decoded.aluSrcPc  = 1'b1;
        decoded.aluSrcImm = 1'b1;
      end
      default: decoded.illegal = 1'b1;
    endcase
    if (decoded.illegal) begin
      decoded.brCond   = brNever;
      decoded.regWrite = 1'b0;
      decoded.memRead  = 1'b0;
      decoded.memWrite = 1'b0;
    end
  end

  // an illegal word must never reach memory as a store
  always_comb begin
    aIllegalNoStore: assert final (!(decoded.illegal && decoded.memWrite))
      else $error("illegal instruction decoded with memWrite");
  end

endmodule

`default_nettype wire

// File: intAlu.sv
// RV32I integer ALU for the ten base operations of aluOpT.
// Shift amounts come from the low five bits of operand B.
`timescale 1ns/1ps
`default_nettype none

module intAlu (
  input  logic [rvExecPkg::xlen-1:0] opA,
  input  logic [rvExecPkg::xlen-1:0] opB,
  input  rvExecPkg::aluOpT           aluOp,
  output logic [rvExecPkg::xlen-1:0] aluOut
);
  import rvExecPkg::*;

  logic [4:0] shamt;
  logic       ltSigned;
  logic       ltUnsigned;

  assign shamt      = opB[4:0];
  assign ltSigned   = $signed(opA) < $signed(opB);
  assign ltUnsigned = opA < opB;

  always_comb begin
    case (aluOp)
      aluAdd:  aluOut = opA + opB;
      aluSub:  aluOut = opA - opB;
      aluSll:  aluOut = opA << shamt;
      aluSlt:  aluOut = {{(xlen-1){1'b0}}, ltSigned};
      aluSltu: aluOut = {{(xlen-1){1'b0}}, ltUnsigned};
      aluXor:  aluOut = opA ^ opB;
      aluSrl:  aluOut = opA >> shamt;
      aluSra:  aluOut = $signed(opA) >>> shamt;  // fills with opA[31]
      aluOr:   aluOut = opA | opB;
      aluAnd:  aluOut = opA & opB;
      default: aluOut = opA + opB;  // unused encodings
    endcase
  end

endmodule

`default_nettype wire

// File: branchCompare.sv
// Branch condition evaluation on the two source register values.
// brAlways marks jumps, brNever everything that does not transfer control.
`timescale 1ns/1ps
`default_nettype none

module branchCompare (
  input  logic [rvExecPkg::xlen-1:0] rs1Data,
  input  logic [rvExecPkg::xlen-1:0] rs2Data,
  input  rvExecPkg::brCondT          brCond,
  output logic                       taken
);
  import rvExecPkg::*;

  logic isEq;
  logic ltS;
  logic ltU;

  assign isEq = (rs1Data == rs2Data);
  assign ltS  = $signed(rs1Data) < $signed(rs2Data);
  assign ltU  = rs1Data < rs2Data;

  always_comb begin
    case (brCond)
      brEq:     taken = isEq;
      brNe:     taken = !isEq;
      brLt:     taken = ltS;
      brGe:     taken = !ltS;
      brLtu:    taken = ltU;
      brGeu:    taken = !ltU;
      brAlways: taken = 1'b1;  // jal, jalr
      default:  taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: alignCheck.sv
// Alignment checks for the execute stage: memory address against access size,
// and the control-transfer target when the branch or jump is taken.
`timescale 1ns/1ps
`default_nettype none

module alignCheck (
  input  logic [rvExecPkg::xlen-1:0] addr,
  input  rvExecPkg::memSizeT         memSize,
  input  logic                       memAccess,
  input  logic [rvExecPkg::xlen-1:0] target,
  input  logic                       taken,
  output logic                       memMisaligned,
  output logic                       pcMisaligned
);
  import rvExecPkg::*;

  always_comb begin
    case (memSize)
      sizeHalf: memMisaligned = memAccess && addr[0];
      sizeWord: memMisaligned = memAccess && (addr[1:0] != 2'b00);
      default:  memMisaligned = 1'b0;  // bytes always fit
    endcase
  end

  assign pcMisaligned = taken && (target[1:0] != 2'b00);  // no compressed ISA

  always_comb begin
    aPcNeedsTaken: assert final (!pcMisaligned || taken)
      else $error("pcMisaligned raised on a not-taken path");
  end

endmodule

`default_nettype wire

// File: rvExec.sv
// Two-stage RV32I execute slice: decode into a stage register, then ALU,
// branch compare and alignment into the result register. Instructions enter
// and results leave over valid/ready; one result per instruction, in order.
`timescale 1ns/1ps
`default_nettype none

module rvExec (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           inValid,
  output logic                           inReady,
  input  logic [rvExecPkg::xlen-1:0]     instWord,
  input  logic [rvExecPkg::xlen-1:0]     pc,
  input  logic [rvExecPkg::xlen-1:0]     rs1Data,
  input  logic [rvExecPkg::xlen-1:0]     rs2Data,
  output logic                           outValid,
  input  logic                           outReady,
  output logic [rvExecPkg::xlen-1:0]     result,
  output logic [rvExecPkg::regAddrW-1:0] rd,
  output logic                           regWrite,
  output logic [rvExecPkg::xlen-1:0]     nextPc,
  output logic [rvExecPkg::xlen-1:0]     memAddr,
  output logic [rvExecPkg::xlen-1:0]     storeData,
  output rvExecPkg::memSizeT             memSize,
  output logic                           memRead,
  output logic                           memWrite,
  output rvExecPkg::haltCauseT           haltCause
);
  import rvExecPkg::*;

  decodedT         decIn;
  decodedT         decQ;
  logic            decValid;
  logic            exReady;   // stage two can take the decoded entry
  execResultT      exIn;
  execResultT      exQ;
  logic [xlen-1:0] opA;
  logic [xlen-1:0] opB;
  logic [xlen-1:0] aluOut;
  logic [xlen-1:0] pcPlus4;
  logic            taken;
  logic            memMisaligned;
  logic            pcMisaligned;
  logic            halted;

  instDecoder decoder (.instWord(instWord), .pc(pc), .rs1Data(rs1Data),
                       .rs2Data(rs2Data), .decoded(decIn));

  pipeReg #(.payloadT(decodedT)) decStage (
    .clk(clk), .arstN(arstN), .inValid(inValid), .inReady(inReady), .inData(decIn),
    .outValid(decValid), .outReady(exReady), .outData(decQ));

  assign opA     = decQ.aluSrcPc  ? decQ.pc  : decQ.rs1Data;
  assign opB     = decQ.aluSrcImm ? decQ.imm : decQ.rs2Data;
  assign pcPlus4 = decQ.pc + xlen'(4);

  intAlu alu (.opA(opA), .opB(opB), .aluOp(decQ.aluOp), .aluOut(aluOut));

  branchCompare brCmp (.rs1Data(decQ.rs1Data), .rs2Data(decQ.rs2Data),
                       .brCond(decQ.brCond), .taken(taken));

  alignCheck align (.addr(aluOut), .memSize(decQ.memSize),
                    .memAccess(decQ.memRead || decQ.memWrite), .target(aluOut),
                    .taken(taken), .memMisaligned(memMisaligned),
                    .pcMisaligned(pcMisaligned));

  always_comb begin
    exIn.rd        = decQ.rd;
    exIn.nextPc    = taken ? aluOut : pcPlus4;  // branch pc+imm, jalr rs1+imm
    exIn.memAddr   = aluOut;
    exIn.storeData = decQ.rs2Data;
    exIn.memSize   = decQ.memSize;
    case (decQ.wbSel)
      wbPc4:   exIn.result = pcPlus4;
      wbImm:   exIn.result = decQ.imm;
      default: exIn.result = aluOut;
    endcase
    // illegal first, then target, then data address
    if (decQ.illegal) begin
      exIn.haltCause = haltIllegal;
    end else if (pcMisaligned) begin
      exIn.haltCause = haltPcAlign;
    end else if (memMisaligned) begin
      exIn.haltCause = haltMemAlign;
    end else begin
      exIn.haltCause = haltNone;
    end
    halted        = (exIn.haltCause != haltNone);
    exIn.regWrite = decQ.regWrite && !halted;
    exIn.memRead  = decQ.memRead  && !halted;
    exIn.memWrite = decQ.memWrite && !halted;
  end

  pipeReg #(.payloadT(execResultT)) exStage (
    .clk(clk), .arstN(arstN), .inValid(decValid), .inReady(exReady), .inData(exIn),
    .outValid(outValid), .outReady(outReady), .outData(exQ));

  assign result    = exQ.result;
  assign rd        = exQ.rd;
  assign regWrite  = exQ.regWrite;
  assign nextPc    = exQ.nextPc;
  assign memAddr   = exQ.memAddr;
  assign storeData = exQ.storeData;
  assign memSize   = exQ.memSize;
  assign memRead   = exQ.memRead;
  assign memWrite  = exQ.memWrite;
  assign haltCause = exQ.haltCause;

endmodule

`default_nettype wire

// File: tbRvExec.sv
// Self-checking testbench for rvExec. Runs the instruction table twice:
// first with outReady held high to check the two-cycle latency, then with
// random back-pressure to check that every result arrives once and in order.
`timescale 1ns/1ps
`default_nettype none

module tbRvExec;
  import rvExecPkg::*;

  localparam logic [1:0] kAlu = 2'd0;  // result and nextPc checked
  localparam logic [1:0] kMem = 2'd1;  // plus memAddr, memSize, storeData
  localparam logic [1:0] kIll = 2'd2;  // halt and write flags only

  typedef struct packed {
    logic [xlen-1:0]     inst;
    logic [xlen-1:0]     pc;
    logic [xlen-1:0]     rs1;
    logic [xlen-1:0]     rs2;
    logic [xlen-1:0]     result;
    logic [regAddrW-1:0] rd;
    logic                regWrite;
    logic [xlen-1:0]     nextPc;
    logic [xlen-1:0]     memAddr;
    memSizeT             memSize;
    logic                memWrite;
    haltCauseT           halt;
    logic [1:0]          kind;
  } vecT;

  logic                clk;
  logic                arstN;
  logic                inValid;
  logic                inReady;
  logic [xlen-1:0]     instWord;
  logic [xlen-1:0]     pc;
  logic [xlen-1:0]     rs1Data;
  logic [xlen-1:0]     rs2Data;
  logic                outValid;
  logic                outReady;
  logic [xlen-1:0]     result;
  logic [regAddrW-1:0] rd;
  logic                regWrite;
  logic [xlen-1:0]     nextPc;
  logic [xlen-1:0]     memAddr;
  logic [xlen-1:0]     storeData;
  memSizeT             memSize;
  logic                memRead;
  logic                memWrite;
  haltCauseT           haltCause;

  vecT    tbl[$];
  integer seed        = 32'h8908;
  int     total       = 0;  // table entries times passes
  int     stallLeft   = 0;
  logic   randomReady = 1'b0;
  int     cyc         = 0;
  int     inTimes[$];       // cycle of each input transfer
  bit     strictQ[$];       // latency must be exactly two
  int     outCount    = 0;
  int     passCount   = 0;
  int     failCount   = 0;
  logic   testOk      = 1'b1;

  rvExec UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // instruction encoders, x1/x2 as sources and x5 as destination
  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [6:0] op);
    return {f7, 5'd2, 5'd1, f3, 5'd5, op};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] f3,
                                       input logic [6:0] op);
    return {imm, 5'd1, f3, 5'd5, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [2:0] f3);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], opStore};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], opBranch};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [6:0] op);
    return {imm, 5'd5, op};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd5, opJal};
  endfunction

  task automatic addVec(input logic [31:0] inst, input logic [31:0] pcV,
                        input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] res, input logic rw, input logic [31:0] npc,
                        input memSizeT size, input logic mw, input haltCauseT halt,
                        input logic [1:0] kind);
    vecT v;
    v.inst     = inst;
    v.pc       = pcV;
    v.rs1      = a;
    v.rs2      = b;
    v.result   = res;
    v.rd       = 5'd5;
    v.regWrite = rw;
    v.nextPc   = npc;
    v.memAddr  = res;  // ALU output on loads and stores
    v.memSize  = size;
    v.memWrite = mw;
    v.halt     = halt;
    v.kind     = kind;
    tbl.push_back(v);
  endtask

  task automatic aluVec(input logic [31:0] inst, input logic [31:0] a,
                        input logic [31:0] b, input logic [31:0] res);
    addVec(inst, 32'h100, a, b, res, 1'b1, 32'h104, sizeByte, 1'b0, haltNone, kAlu);
  endtask

  task automatic brVec(input logic [31:0] inst, input logic [31:0] a, input logic [31:0] b,
                       input logic [31:0] target, input logic taken, input haltCauseT halt);
    addVec(inst, 32'h300, a, b, target, 1'b0, taken ? target : 32'h304, sizeByte, 1'b0,
           halt, kAlu);
  endtask

  task automatic memVec(input logic [31:0] inst, input logic [31:0] addr, input memSizeT size,
                        input logic isStore, input haltCauseT halt);
    addVec(inst, 32'h400, 32'h1000, 32'hDEAD_BEEF, addr, !isStore && (halt == haltNone),
           32'h404, size, isStore && (halt == haltNone), halt, kMem);
  endtask

  task automatic illVec(input logic [31:0] inst);
    addVec(inst, 32'h500, 32'h1, 32'h2, 32'h0, 1'b0, 32'h0, sizeByte, 1'b0, haltIllegal, kIll);
  endtask

  task automatic buildTable();
    aluVec(encR(7'h00, 3'd0, opCompute), 32'd5, 32'd7, 32'd12);
    aluVec(encR(7'h20, 3'd0, opCompute), 32'd5, 32'd7, 32'hFFFF_FFFE);
    aluVec(encR(7'h00, 3'd1, opCompute), 32'd1, 32'h24, 32'h10);  // shamt from low bits
    aluVec(encR(7'h00, 3'd2, opCompute), 32'hFFFF_FFFF, 32'd1, 32'd1);
    aluVec(encR(7'h00, 3'd3, opCompute), 32'hFFFF_FFFF, 32'd1, 32'd0);
    aluVec(encR(7'h00, 3'd4, opCompute), 32'hF0F0_F0F0, 32'h0FF0_0FF0, 32'hFF00_FF00);
    aluVec(encR(7'h00, 3'd5, opCompute), 32'h8000_0000, 32'd4, 32'h0800_0000);
    aluVec(encR(7'h20, 3'd5, opCompute), 32'h8000_0000, 32'd4, 32'hF800_0000);
    aluVec(encR(7'h00, 3'd6, opCompute), 32'h0000_00F0, 32'h0000_0F00, 32'h0000_0FF0);
    aluVec(encR(7'h00, 3'd7, opCompute), 32'hFF00_FF00, 32'h0FF0_0FF0, 32'h0F00_0F00);
    aluVec(encI(12'hFFD, 3'd0, opICompute), 32'd10, 32'd0, 32'd7);
    aluVec(encI(12'hFFF, 3'd2, opICompute), 32'hFFFF_FFFB, 32'd0, 32'd1);
    aluVec(encI(12'hFFF, 3'd3, opICompute), 32'd5, 32'd0, 32'd1);
    aluVec(encI(12'h0FF, 3'd4, opICompute), 32'h0F, 32'd0, 32'hF0);
    aluVec(encI(12'h00F, 3'd6, opICompute), 32'h100, 32'd0, 32'h10F);
    aluVec(encI(12'h0F0, 3'd7, opICompute), 32'hFFFF, 32'd0, 32'hF0);
    aluVec(encI(12'h005, 3'd1, opICompute), 32'd3, 32'd0, 32'h60);
    aluVec(encI(12'h004, 3'd5, opICompute), 32'hFFFF_FF00, 32'd0, 32'h0FFF_FFF0);
    aluVec(encI(12'h404, 3'd5, opICompute), 32'hFFFF_FF00, 32'd0, 32'hFFFF_FFF0);  // srai
    aluVec(encU(20'h12345, opLui), 32'd0, 32'd0, 32'h1234_5000);
    aluVec(encU(20'h00001, opAuipc), 32'd0, 32'd0, 32'h1100);
    addVec(encJ(21'h40), 32'h200, 32'd0, 32'd0, 32'h204, 1'b1, 32'h240, sizeByte, 1'b0,
           haltNone, kAlu);
    addVec(encI(12'h010, 3'd0, opJalr), 32'h200, 32'h1000, 32'd0, 32'h204, 1'b1, 32'h1010,
           sizeByte, 1'b0, haltNone, kAlu);
    addVec(encI(12'h002, 3'd0, opJalr), 32'h200, 32'h1000, 32'd0, 32'h204, 1'b0, 32'h1002,
           sizeByte, 1'b0, haltPcAlign, kAlu);
    brVec(encB(13'h020, 3'd0), 32'd7, 32'd7, 32'h320, 1'b1, haltNone);
    brVec(encB(13'h020, 3'd0), 32'd7, 32'd8, 32'h320, 1'b0, haltNone);
    brVec(encB(13'h020, 3'd1), 32'd7, 32'd8, 32'h320, 1'b1, haltNone);
    brVec(encB(13'h020, 3'd1), 32'd7, 32'd7, 32'h320, 1'b0, haltNone);
    brVec(encB(13'h020, 3'd4), 32'hFFFF_FFFF, 32'd1, 32'h320, 1'b1, haltNone);
    brVec(encB(13'h020, 3'd4), 32'd1, 32'hFFFF_FFFF, 32'h320, 1'b0, haltNone);
    brVec(encB(13'h020, 3'd5), 32'd1, 32'hFFFF_FFFF, 32'h320, 1'b1, haltNone);
    brVec(encB(13'h020, 3'd5), 32'hFFFF_FFFF, 32'd1, 32'h320, 1'b0, haltNone);
    brVec(encB(13'h020, 3'd6), 32'd1, 32'hFFFF_FFFF, 32'h320, 1'b1, haltNone);
    brVec(encB(13'h020, 3'd6), 32'hFFFF_FFFF, 32'd1, 32'h320, 1'b0, haltNone);
    brVec(encB(13'h020, 3'd7), 32'hFFFF_FFFF, 32'd1, 32'h320, 1'b1, haltNone);
    brVec(encB(13'h020, 3'd7), 32'd1, 32'hFFFF_FFFF, 32'h320, 1'b0, haltNone);
    brVec(encB(13'h022, 3'd0), 32'd7, 32'd7, 32'h322, 1'b1, haltPcAlign);
    brVec(encB(13'h022, 3'd0), 32'd7, 32'd8, 32'h322, 1'b0, haltNone);  // not taken, no halt
    memVec(encI(12'h008, 3'd2, opLoad), 32'h1008, sizeWord, 1'b0, haltNone);
    memVec(encI(12'h002, 3'd1, opLoad), 32'h1002, sizeHalf, 1'b0, haltNone);
    memVec(encI(12'h003, 3'd0, opLoad), 32'h1003, sizeByte, 1'b0, haltNone);
    memVec(encI(12'h001, 3'd1, opLoad), 32'h1001, sizeHalf, 1'b0, haltMemAlign);
    memVec(encI(12'h002, 3'd2, opLoad), 32'h1002, sizeWord, 1'b0, haltMemAlign);
    memVec(encS(12'h004, 3'd2), 32'h1004, sizeWord, 1'b1, haltNone);
    memVec(encS(12'h006, 3'd1), 32'h1006, sizeHalf, 1'b1, haltNone);
    memVec(encS(12'hFFF, 3'd0), 32'h0FFF, sizeByte, 1'b1, haltNone);
    memVec(encS(12'h002, 3'd2), 32'h1002, sizeWord, 1'b1, haltMemAlign);
    memVec(encS(12'h003, 3'd1), 32'h1003, sizeHalf, 1'b1, haltMemAlign);
    illVec(32'h0000_007F);                   // unknown opcode
    illVec(encR(7'h01, 3'd0, opCompute));    // mul
    illVec(encB(13'h020, 3'd2));
    illVec(encI(12'h000, 3'd4, opLoad));     // lbu
    illVec(encR(7'h20, 3'd7, opCompute));
  endtask

  task automatic checkWord(input string name, input logic [xlen-1:0] got,
                           input logic [xlen-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      testOk = 1'b0;
    end
  endtask

  task automatic checkSize(input string name, input memSizeT got, input memSizeT exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      testOk = 1'b0;
    end
  endtask

  task automatic checkCause(input string name, input haltCauseT got, input haltCauseT exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      testOk = 1'b0;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      testOk = 1'b0;
    end
  endtask

  task automatic checkEntry(input vecT v);
    checkCause("haltCause", haltCause, v.halt);
    checkBit("regWrite", regWrite, v.regWrite);
    checkBit("memWrite", memWrite, v.memWrite);
    checkBit("memRead", memRead, (v.kind == kMem) && v.regWrite);  // a load that goes ahead
    if (v.regWrite) begin
      checkWord("rd", 32'(rd), 32'(v.rd));
    end
    if (v.kind != kIll) begin
      checkWord("result", result, v.result);
      checkWord("nextPc", nextPc, v.nextPc);
    end
    if (v.kind == kMem) begin
      checkWord("memAddr", memAddr, v.memAddr);
      checkSize("memSize", memSize, v.memSize);
      checkWord("storeData", storeData, v.rs2);
    end
  endtask

  task automatic reportTest(input string label);
    if (testOk) begin
      passCount++;
      $display("%s ok", label);
    end else begin
      failCount++;
      $display("%s failed", label);
    end
    testOk = 1'b1;
  endtask

  // one step to the next drive point, with outReady updated there
  task automatic nextCycle();
    @(posedge clk);
    #1;
    if (!randomReady) begin
      outReady = 1'b1;
    end else if (stallLeft > 0) begin
      outReady = 1'b0;
      stallLeft--;
    end else if (($random(seed) & 7) == 0) begin
      outReady = 1'b0;
      stallLeft = 2 + ($random(seed) & 3);  // hold low for a few cycles
    end else begin
      outReady = 1'b1;
    end
  endtask

  task automatic applyEntry(input vecT v);
    logic accepted;
    instWord = v.inst;
    pc       = v.pc;
    rs1Data  = v.rs1;
    rs2Data  = v.rs2;
    inValid  = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = inReady;  // inputs are stable until the next edge
      nextCycle();
    end
    inValid = 1'b0;
  endtask

  // handshakes are sampled mid-cycle, the transfer happens on the next edge
  always @(negedge clk) begin : monitor
    int  lat;
    vecT v;
    if (arstN) begin
      cyc = cyc + 1;
      if (inValid && inReady) begin
        inTimes.push_back(cyc);
        strictQ.push_back(!randomReady);
      end
      if (outValid && outReady) begin
        if (inTimes.size() == 0) begin
          $display("result delivered with no instruction in flight at %0t", $time);
          failCount++;
        end else begin
          v   = tbl[outCount % tbl.size()];
          lat = cyc - inTimes.pop_front();
          checkEntry(v);
          if (strictQ.pop_front() && lat != 2) begin
            $display("result came %0d cycles after its input instead of 2", lat);
            testOk = 1'b0;
          end
          reportTest($sformatf("test %0d inst %h", outCount, v.inst));
          outCount++;
        end
      end
    end
  end

  initial begin : driver
    int gap;
    arstN    = 1'b0;
    inValid  = 1'b0;
    instWord = '0;
    pc       = '0;
    rs1Data  = '0;
    rs2Data  = '0;
    outReady = 1'b0;
    buildTable();
    total = 2 * tbl.size();
    repeat (10) @(posedge clk);
    #1;
    arstN    = 1'b1;
    outReady = 1'b1;
    checkBit("inReady", inReady, 1'b1);
    checkBit("outValid", outValid, 1'b0);
    reportTest("reset state");
    for (int pass = 0; pass < 2; pass++) begin
      randomReady = (pass == 1);
      foreach (tbl[i]) begin
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) nextCycle();
        applyEntry(tbl[i]);
      end
      while (outCount < (pass + 1) * tbl.size()) begin
        nextCycle();
      end
    end
    repeat (4) nextCycle();  // room for a stray extra result
    $display("%0d tests, %0d passed, %0d failed", passCount + failCount, passCount,
             failCount);
    if (failCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    wait (total > 0);
    #(total * 40 * 8);
    $display("timeout: only %0d of %0d results arrived", outCount, total);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: rvExec.f
rvExecPkg.sv
pipeReg.sv
immGen.sv
instDecoder.sv
intAlu.sv
branchCompare.sv
alignCheck.sv
rvExec.sv
tbRvExec.sv

// File: Makefile
# Verilator flow for the rvExec testbench.
# run fails unless the simulation prints the pass line.

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tbRvExec -f rvExec.f -o simRvExec

run: compile
	@out="$$(./obj_dir/simRvExec)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
